// File: include/usi_defs.svh
//--------------------------------------
// Bus widths, address word fields and block map
// Block numbers are 8 bit, CSR offsets 16 bit
// RAM depth must be a power of two, 2 or more
//--------------------------------------
`ifndef usiDefsSvh
`define usiDefsSvh

//--------------------------------------
// Word widths
//--------------------------------------
`define usiDataWidth 32
`define usiAdrsWidth 32

//--------------------------------------
// Address word fields
//--------------------------------------
// Command, see usiCmdE
`define usiCmdMsb 31
`define usiCmdLsb 30
// Target block number
`define usiBlockMsb 23
`define usiBlockLsb 16
// CSR offset sits in bits 15:0
`define usiCsrWidth 16

//--------------------------------------
// Block map
//--------------------------------------
`define usiGpioBlock 8'd1
`define usiRamBlock 8'd6
`define usiSlaveCount 2             // Ready vector width
// Read data of any unmapped block
`define usiSentinel 32'h1234_5678

//--------------------------------------
// Slave sizes
//--------------------------------------
`define gpioWidth 16
`define ramDepthDefault 64          // Words

`endif

// File: src/usiPkg.sv
//--------------------------------------
// Shared types of the bus subsystem
// Field positions come from usi_defs.svh
// Command 3 is reserved and never sent
//--------------------------------------
`include "usi_defs.svh"

package usiPkg;

	// Command field of the address word
	typedef enum logic [1:0]
	{
		cmdIdle  = 2'd0,
		cmdWrite = 2'd1,
		cmdRead  = 2'd2,
		cmdRsvd  = 2'd3     // Reserved, not implemented
	} usiCmdE;

	// GPIO CSR offsets
	typedef enum logic [`usiCsrWidth-1:0]
	{
		regOut = 16'd0,     // Output level, rw
		regOe  = 16'd1,     // Output enable, rw
		regIn  = 16'd2      // Synchronized inputs, ro
	} gpioRegE;

	typedef logic [`usiBlockMsb-`usiBlockLsb:0] usiBlockT;
	typedef logic [`usiCsrWidth-1:0] usiCsrT;
	typedef logic [`usiDataWidth-1:0] usiDataT;

	//--------------------------------------
	// Address word split into its fields
	//--------------------------------------
	typedef struct packed
	{
		usiCmdE   cmd;      // 31:30
		logic [`usiCmdLsb-`usiBlockMsb-2:0] pad;    // 29:24, unused
		usiBlockT block;    // 23:16
		usiCsrT   csr;      // 15:0
	} usiAdrsT;

endpackage

// File: src/usiBusIf.sv
//--------------------------------------
// One slave link of the interconnect
// Command and write data arrive already registered
// rdEd high means the slave takes commands
//--------------------------------------
`timescale 1ns/1ps
`include "usi_defs.svh"

interface usiBusIf;
	import usiPkg::*;

	usiDataT wd;                        // Write data
	logic [`usiAdrsWidth-1:0] adrs;     // Cmd, block, CSR offset
	usiDataT rd;                        // Registered CSR content
	logic rdEd;                         // Slave ready

	// Interconnect side
	modport master
	(
		output wd,
		output adrs,
		input  rd,
		input  rdEd
	);

	// Slave block side
	modport slave
	(
		input  wd,
		input  adrs,
		output rd,
		output rdEd
	);

endinterface

// File: src/usiInterconnect.sv
//--------------------------------------
// Registered interconnect, one master, two slaves
// Command reaches the slaves one edge later
// Read data at the master three edges after the command
// No stall, no error response, no arbitration
// Ready bit 0 is GPIO, bit 1 is RAM
//--------------------------------------
`timescale 1ns/1ps
`include "usi_defs.svh"

module usiInterconnect
(
	input  logic iUsiClk,
	input  logic rstN,
	// Master side
	input  logic [`usiDataWidth-1:0] usiWd,
	input  logic [`usiAdrsWidth-1:0] usiAdrs,
	output usiPkg::usiDataT usiRd,
	output logic [`usiSlaveCount-1:0] usiREd,
	// Slave links
	usiBusIf.master gpioBus,
	usiBusIf.master ramBus
);
	import usiPkg::*;

	//--------------------------------------
	// Broadcast stage
	//--------------------------------------
	usiDataT wdQ;                       // Payload, no reset
	logic [`usiAdrsWidth-1:0] adrsQ;

	always_ff @(posedge iUsiClk)
	begin
		wdQ <= usiWd;
	end

	always_ff @(posedge iUsiClk or negedge rstN)
	begin
		if (!rstN)
		begin
			adrsQ <= '0;                // Command idle
		end
		else
		begin
			adrsQ <= usiAdrs;
		end
	end

	// Same copy to every slave, each slave decodes its own block
	assign gpioBus.wd   = wdQ;
	assign gpioBus.adrs = adrsQ;
	assign ramBus.wd    = wdQ;
	assign ramBus.adrs  = adrsQ;

	//--------------------------------------
	// Return stage
	//--------------------------------------
	// Block field shift, matches slave read latency
	usiBlockT blockPipe [2];

	always_ff @(posedge iUsiClk or negedge rstN)
	begin
		if (!rstN)
		begin
			blockPipe[0] <= '0;
			blockPipe[1] <= '0;
			usiRd <= '0;
			usiREd <= '0;
		end
		else
		begin
			blockPipe[0] <= usiAdrs[`usiBlockMsb:`usiBlockLsb];
			blockPipe[1] <= blockPipe[0];

			// Rd from the slave that was addressed two edges ago
			case (blockPipe[1])
				`usiGpioBlock: usiRd <= gpioBus.rd;
				`usiRamBlock:  usiRd <= ramBus.rd;
				default:       usiRd <= `usiSentinel;  // Makes decode bugs easy to spot
			endcase

			usiREd <= {ramBus.rdEd, gpioBus.rdEd};
		end
	end

	//--------------------------------------
	// Checks
	//--------------------------------------
	// Reserved command is not implemented
	assert property (@(posedge iUsiClk) disable iff (!rstN)
		usiCmdE'(usiAdrs[`usiCmdMsb:`usiCmdLsb]) != cmdRsvd)
	else
		$error("reserved command on the master address word");

	// Slaves must hold ready low through reset
	assert property (@(posedge iUsiClk)
		$rose(rstN) |=> (usiREd == '0))
	else
		$error("ready bits high right after reset release");

endmodule

// File: src/gpioCsr.sv
//--------------------------------------
// GPIO CSR block
// Offsets 0 out, 1 output enable, 2 inputs
// Inputs pass two flops, no debounce
// Unknown offsets read zero, writes to them drop
//--------------------------------------
`timescale 1ns/1ps
`include "usi_defs.svh"

module gpioCsr
(
	input  logic iUsiClk,
	input  logic rstN,
	input  logic [`gpioWidth-1:0] gpioIn,
	output logic [`gpioWidth-1:0] gpioOut,
	output logic [`gpioWidth-1:0] gpioOe,
	usiBusIf.slave bus
);
	import usiPkg::*;

	usiAdrsT cmdWord;                   // Registered address word, split
	logic readyQ;
	logic wrHit;
	logic [`gpioWidth-1:0] inMeta;      // First sync flop
	logic [`gpioWidth-1:0] inReg;       // Second sync flop, regIn

	assign cmdWord = bus.adrs;

	// Write only when addressed and ready
	assign wrHit = readyQ && (cmdWord.cmd == cmdWrite) &&
		(cmdWord.block == `usiGpioBlock);

	//--------------------------------------
	// Control registers
	//--------------------------------------
	always_ff @(posedge iUsiClk or negedge rstN)
	begin
		if (!rstN)
		begin
			gpioOut <= '0;
			gpioOe <= '0;
			readyQ <= 1'b0;
		end
		else
		begin
			readyQ <= 1'b1;             // Ready from first edge
			if (wrHit)
			begin
				case (cmdWord.csr)
					regOut: gpioOut <= bus.wd[`gpioWidth-1:0];
					regOe:  gpioOe <= bus.wd[`gpioWidth-1:0];
					default: ;          // regIn is read-only
				endcase
			end
		end
	end

	// Input synchronizer
	always_ff @(posedge iUsiClk or negedge rstN)
	begin
		if (!rstN)
		begin
			inMeta <= '0;
			inReg <= '0;
		end
		else
		begin
			inMeta <= gpioIn;
			inReg <= inMeta;
		end
	end

	//--------------------------------------
	// Read path
	//--------------------------------------
	// Addressed CSR registered every cycle
	always_ff @(posedge iUsiClk or negedge rstN)
	begin
		if (!rstN)
		begin
			bus.rd <= '0;
		end
		else
		begin
			case (cmdWord.csr)
				regOut:  bus.rd <= usiDataT'(gpioOut);     // Zero extended
				regOe:   bus.rd <= usiDataT'(gpioOe);
				regIn:   bus.rd <= usiDataT'(inReg);
				default: bus.rd <= '0;
			endcase
		end
	end

	assign bus.rdEd = readyQ;

	// Master must never push unknown address or data here
	assert property (@(posedge iUsiClk) disable iff (!rstN)
		!$isunknown(bus.rd))
	else
		$error("GPIO read data unknown");

endmodule

// File: src/scratchRam.sv
//--------------------------------------
// Scratch RAM slave
// ramDepth must be a power of two, 2 or more
// Offset wraps modulo ramDepth
// Not ready for ramDepth cycles after reset
//--------------------------------------
`timescale 1ns/1ps
`include "usi_defs.svh"

module scratchRam #(
	parameter int ramDepth = `ramDepthDefault
)(
	input  logic iUsiClk,
	input  logic rstN,
	usiBusIf.slave bus
);
	import usiPkg::*;

	localparam int idxWidth = $clog2(ramDepth);

	typedef enum logic
	{
		clearing,                       // Zero fill after reset
		serving
	} ramStateE;

	ramStateE state;
	usiAdrsT cmdWord;
	logic [idxWidth-1:0] clrIdx;
	logic [idxWidth-1:0] busIdx;        // Wrapped CSR offset
	logic [idxWidth-1:0] memIdx;
	usiDataT memWd;
	logic wrReq;
	logic memWe;
	usiDataT mem [ramDepth];

	assign cmdWord = bus.adrs;
	assign busIdx = cmdWord.csr[idxWidth-1:0];

	// Write command aimed at this block
	assign wrReq = (cmdWord.cmd == cmdWrite) && (cmdWord.block == `usiRamBlock);

	//--------------------------------------
	// Clear FSM
	//--------------------------------------
	always_ff @(posedge iUsiClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= clearing;
			clrIdx <= '0;
		end
		else if (state == clearing)
		begin
			clrIdx <= clrIdx + 1'b1;
			if (clrIdx == idxWidth'(ramDepth - 1))
			begin
				state <= serving;       // Last word cleared
			end
		end
	end

	// Clear owns the write port until serving
	assign memWe = (state == clearing) || wrReq;
	assign memIdx = (state == clearing) ? clrIdx : busIdx;
	assign memWd = (state == clearing) ? '0 : bus.wd;

	//--------------------------------------
	// Storage
	//--------------------------------------
	always_ff @(posedge iUsiClk)
	begin
		if (memWe)
		begin
			mem[memIdx] <= memWd;
		end
		bus.rd <= mem[busIdx];          // Old word on same-edge write
	end

	assign bus.rdEd = (state == serving);

	// Master has to wait for ready before writing
	assert property (@(posedge iUsiClk) disable iff (!rstN)
		(state == clearing) |-> !wrReq)
	else
		$error("RAM write while clearing");

endmodule

// File: src/usiSubsystem.sv
//--------------------------------------
// Bus subsystem top level
// Block 1 GPIO, block 6 scratch RAM
// Other blocks read the sentinel
// Read data three edges after the command
// usiREd bit 0 GPIO, bit 1 RAM
//--------------------------------------
`timescale 1ns/1ps
`include "usi_defs.svh"

module usiSubsystem
(
	input  logic iUsiClk,
	input  logic rstN,
	// Bus master
	input  logic [`usiDataWidth-1:0] usiWd,
	input  logic [`usiAdrsWidth-1:0] usiAdrs,
	output logic [`usiDataWidth-1:0] usiRd,
	output logic [`usiSlaveCount-1:0] usiREd,
	// GPIO pins
	input  logic [`gpioWidth-1:0] gpioIn,
	output logic [`gpioWidth-1:0] gpioOut,
	output logic [`gpioWidth-1:0] gpioOe
);

	//--------------------------------------
	// Slave links
	//--------------------------------------
	usiBusIf gpioBus ();
	usiBusIf ramBus ();

	// Broadcast and read-back
	usiInterconnect u_interconnect
	(
		.iUsiClk (iUsiClk),
		.rstN    (rstN),
		.usiWd   (usiWd),
		.usiAdrs (usiAdrs),
		.usiRd   (usiRd),
		.usiREd  (usiREd),
		.gpioBus (gpioBus.master),
		.ramBus  (ramBus.master)
	);

	gpioCsr u_gpioCsr
	(
		.iUsiClk (iUsiClk),
		.rstN    (rstN),
		.gpioIn  (gpioIn),
		.gpioOut (gpioOut),
		.gpioOe  (gpioOe),
		.bus     (gpioBus.slave)
	);

	scratchRam #(
		.ramDepth (`ramDepthDefault)
	) u_scratchRam (
		.iUsiClk (iUsiClk),
		.rstN    (rstN),
		.bus     (ramBus.slave)
	);

endmodule

// File: bench/usiSubsystemTb.sv
//--------------------------------------
// Random testbench of the bus subsystem
// Model applies commands in issue order
// Read data checked three edges after issue
// Fixed seed and a cycle limit on the run
//--------------------------------------
`timescale 1ns/1ps
`include "usi_defs.svh"

module usiSubsystemTb;
	import usiPkg::*;

	localparam int ramDepth = `ramDepthDefault;
	localparam int rstCycles = 8;
	// Test lengths in cycles with drain slots
	localparam int resetLen = rstCycles + 4;
	localparam int ramLen = 200 + 3;
	localparam int gpioRegLen = 60 + 6 * 3 + 3;
	localparam int gpioInLen = 20 * 6 + 3;
	localparam int unmapLen = 40 + 3 + 16 + 3 + 3;
	localparam int pipeLen = 100 + 3;
	localparam int timeoutCycles = resetLen + ramLen + gpioRegLen + gpioInLen +
		unmapLen + pipeLen + ramDepth + 100;

	logic iUsiClk;
	logic rstN;
	logic [`usiDataWidth-1:0] usiWd;
	logic [`usiAdrsWidth-1:0] usiAdrs;
	logic [`usiDataWidth-1:0] usiRd;
	logic [`usiSlaveCount-1:0] usiREd;
	logic [`gpioWidth-1:0] gpioIn;
	logic [`gpioWidth-1:0] gpioOut;
	logic [`gpioWidth-1:0] gpioOe;
	logic [`gpioWidth-1:0] gpioInNext;  // Pin value for the next slot

	//--------------------------------------
	// Reference model state
	//--------------------------------------
	usiDataT ramModel [ramDepth];
	logic [`gpioWidth-1:0] outModel;
	logic [`gpioWidth-1:0] oeModel;
	logic [`gpioWidth-1:0] syncA;       // Mirror of the input synchronizer
	logic [`gpioWidth-1:0] syncB;

	usiDataT expQ [$];                  // One entry per issued slot
	bit chkQ [$];
	int checkCount;
	int errCount;
	int testErrBase;
	int cycleCount;

	usiSubsystem dut
	(
		.iUsiClk (iUsiClk),
		.rstN    (rstN),
		.usiWd   (usiWd),
		.usiAdrs (usiAdrs),
		.usiRd   (usiRd),
		.usiREd  (usiREd),
		.gpioIn  (gpioIn),
		.gpioOut (gpioOut),
		.gpioOe  (gpioOe)
	);

	initial iUsiClk = 1'b0;
	always #2 iUsiClk = ~iUsiClk;       // 4 ns period

	always @(posedge iUsiClk or negedge rstN)
	begin
		if (!rstN)
		begin
			syncA <= '0;
			syncB <= '0;
		end
		else
		begin
			syncA <= gpioIn;
			syncB <= syncA;
		end
	end

	// Run limit
	always @(posedge iUsiClk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= timeoutCycles)
		begin
			$display("Timeout: run passed %0d cycles without finishing", timeoutCycles);
			$display("=== FAIL ===");
			$finish;
		end
	end

	//--------------------------------------
	// Compare tasks
	//--------------------------------------
	task automatic compareData(input string name, input usiDataT exp, input usiDataT act);
		checkCount++;
		if (act !== exp)
		begin
			errCount++;
			$display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic compareReady(input string name, input logic [`usiSlaveCount-1:0] exp,
		input logic [`usiSlaveCount-1:0] act);
		checkCount++;
		if (act !== exp)
		begin
			errCount++;
			$display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	task automatic compareGpio(input string name, input logic [`gpioWidth-1:0] exp,
		input logic [`gpioWidth-1:0] act);
		checkCount++;
		if (act !== exp)
		begin
			errCount++;
			$display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	// Apply one command to the model and return its read data
	task automatic modelIssue(input usiCmdE cmd, input usiBlockT blk, input usiCsrT csr,
		input usiDataT wd, output usiDataT exp, output bit chk);
		int idx;
		idx = csr % ramDepth;           // Offset wraps on the RAM
		exp = '0;
		chk = (cmd == cmdRead);
		if (cmd == cmdWrite && blk == `usiRamBlock)
			ramModel[idx] = wd;
		else if (cmd == cmdWrite && blk == `usiGpioBlock && csr == 16'd0)
			outModel = wd[`gpioWidth-1:0];
		else if (cmd == cmdWrite && blk == `usiGpioBlock && csr == 16'd1)
			oeModel = wd[`gpioWidth-1:0];
		if (blk == `usiRamBlock)
			exp = ramModel[idx];
		else if (blk == `usiGpioBlock)
		begin
			case (csr)
				16'd0:   exp = usiDataT'(outModel);
				16'd1:   exp = usiDataT'(oeModel);
				16'd2:   exp = usiDataT'(syncB);
				default: exp = '0;      // Unknown offset
			endcase
		end
		else
			exp = `usiSentinel;
	endtask

	// One bus slot that retires the slot issued three edges earlier
	task automatic step(input usiCmdE cmd, input usiBlockT blk, input usiCsrT csr,
		input usiDataT wd);
		usiDataT exp;
		bit chk;
		logic [`usiAdrsWidth-1:0] word;
		@(posedge iUsiClk);
		#0.5;
		if (expQ.size() == 3)
		begin
			exp = expQ.pop_front();
			chk = chkQ.pop_front();
			if (chk)
				compareData("usiRd", exp, usiRd);
		end
		modelIssue(cmd, blk, csr, wd, exp, chk);
		word = '0;
		word[`usiCmdMsb:`usiCmdLsb] = cmd;
		word[`usiBlockMsb:`usiBlockLsb] = blk;
		word[`usiCsrWidth-1:0] = csr;
		usiAdrs = word;
		usiWd = wd;
		gpioIn = gpioInNext;
		expQ.push_back(exp);
		chkQ.push_back(chk);
	endtask

	task automatic idleSlots(input int n);
		repeat (n) step(cmdIdle, 8'd0, 16'd0, '0);
	endtask

	task automatic endTest(input string name);
		$display("Test %s done, %0d failures", name, errCount - testErrBase);
		testErrBase = errCount;
	endtask

	function automatic usiBlockT randUnmapped();
		usiBlockT b;
		b = usiBlockT'($urandom_range(255));
		while (b == `usiGpioBlock || b == `usiRamBlock)
			b = usiBlockT'($urandom_range(255));
		return b;
	endfunction

	//--------------------------------------
	// Test sequence
	//--------------------------------------
	initial
	begin
		int cnt;
		usiCsrT lastCsr;
		usiCsrT csr;
		usiBlockT blk;
		void'($urandom(32'h29d9_559d));
		rstN = 1'b0;
		usiWd = '0;
		usiAdrs = '0;                   // Command idle
		gpioIn = '0;
		gpioInNext = '0;
		outModel = '0;
		oeModel = '0;
		for (int i = 0; i < ramDepth; i++)
			ramModel[i] = '0;
		checkCount = 0;
		errCount = 0;
		testErrBase = 0;
		cycleCount = 0;
		lastCsr = '0;

		// Reset state then RAM clear time
		repeat (rstCycles) @(posedge iUsiClk);
		#0.5;
		compareData("usiRd", '0, usiRd);
		compareReady("usiREd", '0, usiREd);
		compareGpio("gpioOut", '0, gpioOut);
		compareGpio("gpioOe", '0, gpioOe);
		rstN = 1'b1;
		cnt = 0;
		while (!usiREd[1] && cnt < ramDepth + 20)
		begin
			@(posedge iUsiClk);
			#0.5;
			cnt++;
			// GPIO ready after two edges and RAM after clear plus one register
			compareReady("usiREd", {cnt > ramDepth, cnt >= 2}, usiREd);
		end
		if (!usiREd[1])
		begin
			errCount++;
			$display("RAM ready bit never rose after reset");
		end
		else if (cnt != ramDepth + 1)
		begin
			errCount++;
			$display("RAM ready bit rose after %0d cycles instead of %0d", cnt, ramDepth + 1);
		end
		endTest("resetState");

		// RAM traffic where first reads hit cleared words
		for (int i = 0; i < 200; i++)
		begin
			case ($urandom_range(3))
				0:       csr = lastCsr;
				1:       csr = lastCsr + usiCsrT'(ramDepth * $urandom_range(1, 7));   // Alias
				default: csr = usiCsrT'($urandom);
			endcase
			if (i >= 10 && $urandom_range(1) == 1)
				step(cmdWrite, `usiRamBlock, csr, $urandom);
			else
				step(cmdRead, `usiRamBlock, csr, '0);
			lastCsr = csr;
		end
		idleSlots(3);
		endTest("ramTraffic");

		// GPIO registers where a write to regIn must not stick
		for (int i = 0; i < 60; i++)
		begin
			csr = usiCsrT'($urandom_range(3));
			if ($urandom_range(1) == 1)
				step(cmdWrite, `usiGpioBlock, csr, $urandom);
			else
				step(cmdRead, `usiGpioBlock, csr, '0);
			if (i % 10 == 9)
			begin
				idleSlots(3);
				compareGpio("gpioOut", outModel, gpioOut);
				compareGpio("gpioOe", oeModel, gpioOe);
			end
		end
		idleSlots(3);
		endTest("gpioRegisters");

		// Input pins read well after each change
		for (int i = 0; i < 20; i++)
		begin
			gpioInNext = `gpioWidth'($urandom);
			idleSlots(4);
			step(cmdRead, `usiGpioBlock, 16'd2, '0);
			step(cmdRead, `usiGpioBlock, usiCsrT'($urandom_range(1)), '0);
		end
		idleSlots(3);
		endTest("gpioInputs");

		// Unmapped blocks read the sentinel and drop writes
		for (int i = 0; i < 40; i++)
		begin
			blk = randUnmapped();
			if ($urandom_range(1) == 1)
				step(cmdWrite, blk, usiCsrT'($urandom), $urandom);
			else
				step(cmdRead, blk, usiCsrT'($urandom), '0);
		end
		idleSlots(3);
		compareGpio("gpioOut", outModel, gpioOut);
		compareGpio("gpioOe", oeModel, gpioOe);
		for (int i = 0; i < 16; i++)
			step(cmdRead, `usiRamBlock, usiCsrT'($urandom_range(ramDepth - 1)), '0);
		for (int i = 0; i < 3; i++)
			step(cmdRead, `usiGpioBlock, usiCsrT'(i), '0);
		idleSlots(3);
		endTest("unmappedBlocks");

		// Back to back reads across all targets
		for (int i = 0; i < 100; i++)
		begin
			case ($urandom_range(2))
				0:       step(cmdRead, `usiGpioBlock, usiCsrT'($urandom_range(4)), '0);
				1:       step(cmdRead, `usiRamBlock, usiCsrT'($urandom), '0);
				default: step(cmdRead, randUnmapped(), usiCsrT'($urandom), '0);
			endcase
		end
		idleSlots(3);
		compareReady("usiREd", 2'b11, usiREd);
		endTest("pipelinedReads");

		$display("Summary: %0d checks, %0d failures", checkCount, errCount);
		if (errCount == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: usiSubsystem.f
+incdir+include
src/usiPkg.sv
src/usiBusIf.sv
src/usiInterconnect.sv
src/gpioCsr.sv
src/scratchRam.sv
src/usiSubsystem.sv
bench/usiSubsystemTb.sv
